/* sim/rs_vectors.txt */
# D dest opa opb opa_rdy opb_rdy fu rob mask | H hold | L ld_en | B resolve mispredict tag
# E expected next issued dest | F expected full | W idle cycles ; fu 1 alu 2 br 3 load 4 mult
H 1
L 0
D 20 1 2 1 1 1 30 0
D 21 1 2 1 1 1 0 0
D 22 1 2 1 1 1 31 0
D 23 1 2 1 1 1 1 0
H 0
E 20
E 22
E 21
E 23
D 30 5 6 1 1 4 2 0
D 31 30 6 0 1 1 3 0
E 30
E 31
D 40 1 2 1 1 3 4 0
D 41 1 2 1 1 1 5 0
E 41
W 5
L 1
E 40
H 1
D 50 1 2 1 1 1 6 1
D 51 1 2 1 1 1 7 2
D 52 1 2 1 1 1 8 0
B 1 0 2
B 1 1 1
B 1 1 2
H 0
E 51
E 52
H 1
D 60 1 2 1 1 1 9 0
D 61 1 2 1 1 1 10 0
D 62 1 2 1 1 1 11 0
D 63 1 2 1 1 1 12 0
D 64 1 2 1 1 1 13 0
D 65 1 2 1 1 1 14 0
D 66 1 2 1 1 1 15 0
D 67 1 2 1 1 1 16 0
F 1
H 0
F 0
E 60
E 61

/* build.f */
rtl/rs_cfg_pkg.sv
rtl/rs_types_pkg.sv
rtl/rs_entry.sv
rtl/age_select.sv
rtl/wb_slot_sched.sv
rtl/rs_core.sv
rtl/ex_latency_pipe.sv
rtl/rs_top.sv
sim/rs_props.sv
sim/rs_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module rs_tb -o Vrs_tb
	./obj_dir/Vrs_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/rs_tb.sv */
`timescale 1ns/1ps

module rs_tb;

	import rs_cfg_pkg::*;
	import rs_types_pkg::*;

	localparam int RS_ENTRIES = 8;
	localparam int WD_CYC_PER_REC = 40;
	localparam int NTAGS = 1 << PRF_TAG_W;

	logic clk;
	logic rst;
	logic dispatch_vld_i;
	rs_dispatch_t dispatch_i;
	br_event_t br_i;
	logic ld_iss_en_i;
	logic iss_hold_i;
	logic iss_vld_o;
	rs_issue_t iss_o;
	cdb_t cdb_o;
	logic rs_full_o;

	// scoreboard, keyed by dest tag
	bit pend[NTAGS];
	bit a_rdy[NTAGS];
	bit b_rdy[NTAGS];
	int a_tag[NTAGS];
	int b_tag[NTAGS];
	int fu_of[NTAGS];
	int rob_of[NTAGS];
	logic [BR_MASK_W-1:0] mask[NTAGS];

	// expected cdb traffic, indexed by cycle modulo 8
	bit exp_vld[8];
	int exp_tag[8];
	int iss_log[$];

	logic hold_prev;
	logic ld_prev;
	int cyc;
	int wd_cyc;
	int n_rec;
	int fd;

	rs_top #(
		.RS_ENTRIES(RS_ENTRIES)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.dispatch_vld_i(dispatch_vld_i),
		.dispatch_i(dispatch_i),
		.br_i(br_i),
		.ld_iss_en_i(ld_iss_en_i),
		.iss_hold_i(iss_hold_i),
		.iss_vld_o(iss_vld_o),
		.iss_o(iss_o),
		.cdb_o(cdb_o),
		.rs_full_o(rs_full_o)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// unit latency in cycles from issue to cdb
	function automatic int lat_of(int fu);
		case (fu)
			1: return LAT_ALU;
			2: return LAT_BRANCH;
			3: return LAT_LOAD;
			4: return LAT_MULT;
			default: return 0;
		endcase
	endfunction

	function automatic bit work_left();
		for (int i = 0; i < NTAGS; i++) begin
			if (pend[i]) begin
				return 1'b1;
			end
		end
		for (int s = 0; s < 8; s++) begin
			if (exp_vld[s]) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic fail_now(string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(string name, int got, int expv);
		if (got != expv) begin
			fail_now($sformatf("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, expv));
		end
	endtask

	// ************************************************************************
	// monitor, samples at the falling edge
	// ************************************************************************

	always @(negedge clk) begin : mon
		int slot;
		int t;
		int l;
		if (!rst) begin
			cyc++;
			slot = cyc % 8;
			check("cdb_o.vld", cdb_o.vld, exp_vld[slot]);
			if (exp_vld[slot]) begin
				check("cdb_o.tag", cdb_o.tag, exp_tag[slot]);
			end
			exp_vld[slot] = 1'b0;

			if (iss_vld_o) begin
				t = iss_o.dest_tag;
				if (!pend[t]) begin
					fail_now($sformatf("op with dest tag %0d issued but was not waiting", t));
				end
				if (!(a_rdy[t] && b_rdy[t])) begin
					fail_now($sformatf("op with dest tag %0d issued before its sources", t));
				end
				if (hold_prev) begin
					fail_now("an op issued while the hold was raised");
				end
				if (fu_of[t] == 3 && !ld_prev) begin
					fail_now("a load issued while the load lane was disabled");
				end
				check("iss_o.fu_sel", iss_o.fu_sel, fu_of[t]);
				check("iss_o.opa_tag", iss_o.opa_tag, a_tag[t]);
				check("iss_o.opb_tag", iss_o.opb_tag, b_tag[t]);
				check("iss_o.rob_idx", iss_o.rob_idx, rob_of[t]);
				check("iss_o.br_mask", iss_o.br_mask, mask[t]);
				l = lat_of(fu_of[t]);
				slot = (cyc + l) % 8;
				if (exp_vld[slot]) begin
					fail_now("two results were scheduled for the same cdb cycle");
				end
				exp_vld[slot] = 1'b1;
				exp_tag[slot] = t;
				pend[t] = 1'b0;
				iss_log.push_back(t);
			end

			// the vectors never dispatch into a full station
			if (dispatch_vld_i && !(br_i.resolve && br_i.mispredict)) begin
				check("rs_full_o", rs_full_o, 0);
				t = dispatch_i.dest_tag;
				pend[t] = 1'b1;
				a_rdy[t] = dispatch_i.opa_rdy;
				b_rdy[t] = dispatch_i.opb_rdy;
				a_tag[t] = dispatch_i.opa_tag;
				b_tag[t] = dispatch_i.opb_tag;
				fu_of[t] = int'(dispatch_i.fu_sel);
				rob_of[t] = dispatch_i.rob_idx;
				mask[t] = dispatch_i.br_mask;
			end

			// wakeup, then branch upkeep
			for (int i = 0; i < NTAGS; i++) begin
				if (pend[i] && cdb_o.vld) begin
					if (a_tag[i] == cdb_o.tag) a_rdy[i] = 1'b1;
					if (b_tag[i] == cdb_o.tag) b_rdy[i] = 1'b1;
				end
				if (pend[i] && br_i.resolve && (mask[i] & br_i.tag) != 0) begin
					if (br_i.mispredict) begin
						pend[i] = 1'b0;
					end else begin
						mask[i] = mask[i] & ~br_i.tag;
					end
				end
			end
			hold_prev = iss_hold_i;
			ld_prev = ld_iss_en_i;
		end
	end

	// bounded by the number of records read so far
	always @(posedge clk) begin
		wd_cyc++;
		if (wd_cyc > WD_CYC_PER_REC * (n_rec + 2)) begin
			fail_now("watchdog expired, the test stopped making progress");
		end
	end

	// ************************************************************************
	// stimulus
	// ************************************************************************

	initial begin : stim
		string cmd;
		string line;
		int code;
		int v;
		int f[8];
		rst = 1'b1;
		dispatch_vld_i = 1'b0;
		dispatch_i = '0;
		br_i = '0;
		ld_iss_en_i = 1'b0;
		iss_hold_i = 1'b0;
		hold_prev = 1'b0;
		ld_prev = 1'b0;
		fd = $fopen("sim/rs_vectors.txt", "r");
		if (fd == 0) begin
			fail_now("cannot open the vector file sim/rs_vectors.txt");
		end
		repeat (10) @(posedge clk);
		#5;
		rst = 1'b0;

		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", cmd);
			if (code != 1) break;
			if (cmd == "#") begin
				code = $fgets(line, fd);
				continue;
			end
			n_rec++;
			@(posedge clk);
			#5;
			dispatch_vld_i = 1'b0;
			br_i = '0;
			case (cmd)
				"D": begin
					code = $fscanf(fd, "%d %d %d %d %d %d %d %d",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
					if (code != 8) fail_now("a dispatch record in the vector file is malformed");
					dispatch_i.dest_tag = f[0];
					dispatch_i.opa_tag = f[1];
					dispatch_i.opb_tag = f[2];
					dispatch_i.opa_rdy = f[3];
					dispatch_i.opb_rdy = f[4];
					dispatch_i.fu_sel = fu_sel_e'(f[5]);
					dispatch_i.rob_idx = f[6];
					dispatch_i.br_mask = f[7];
					dispatch_vld_i = 1'b1;
				end
				"H": begin
					code = $fscanf(fd, "%d", v);
					iss_hold_i = v;
				end
				"L": begin
					code = $fscanf(fd, "%d", v);
					ld_iss_en_i = v;
				end
				"B": begin
					code = $fscanf(fd, "%d %d %d", f[0], f[1], f[2]);
					br_i.resolve = f[0];
					br_i.mispredict = f[1];
					br_i.tag = f[2];
				end
				"E": begin
					code = $fscanf(fd, "%d", v);
					while (iss_log.size() == 0) begin
						@(posedge clk);
						#5;
					end
					check("iss_o.dest_tag", iss_log.pop_front(), v);
				end
				"F": begin
					code = $fscanf(fd, "%d", v);
					@(negedge clk);
					check("rs_full_o", rs_full_o, v);
				end
				"W": begin
					code = $fscanf(fd, "%d", v);
					repeat (v) @(posedge clk);
					#5;
				end
				default: fail_now($sformatf("unknown record type %s in the vector file", cmd));
			endcase
		end
		$fclose(fd);

		// drain whatever is still in the station
		@(posedge clk);
		#5;
		dispatch_vld_i = 1'b0;
		br_i = '0;
		iss_hold_i = 1'b0;
		ld_iss_en_i = 1'b1;
		while (work_left()) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* sim/rs_props.sv */
`timescale 1ns/1ps

module rs_props (
	input  logic clk,
	input  logic rst,
	input  logic iss_vld_o,
	input  logic iss_hold_i,
	input  rs_types_pkg::cdb_t cdb_o
);

	// issue register is cleared by reset
	a_no_iss_in_rst: assert property (@(posedge clk) rst |=> !iss_vld_o)
		else $error("issue valid seen during reset");

	// output is registered, so look at the hold one cycle back
	a_no_iss_on_hold: assert property (@(posedge clk) disable iff (rst)
		iss_vld_o |-> !$past(iss_hold_i))
		else $error("issue while the hold was raised");

	// each result tag is broadcast once
	a_cdb_no_repeat: assert property (@(posedge clk) disable iff (rst)
		(cdb_o.vld && $past(cdb_o.vld)) |-> (cdb_o.tag != $past(cdb_o.tag)))
		else $error("cdb repeated a tag");

endmodule

bind rs_top rs_props u_props (
	.clk(clk),
	.rst(rst),
	.iss_vld_o(iss_vld_o),
	.iss_hold_i(iss_hold_i),
	.cdb_o(cdb_o)
);

/* rtl/rs_top.sv */
`timescale 1ns/1ps

module rs_top #(
	parameter int RS_ENTRIES = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic dispatch_vld_i,
	input  rs_types_pkg::rs_dispatch_t dispatch_i,
	input  rs_types_pkg::br_event_t br_i,
	input  logic ld_iss_en_i,
	input  logic iss_hold_i,
	output logic iss_vld_o,
	output rs_types_pkg::rs_issue_t iss_o,
	output rs_types_pkg::cdb_t cdb_o,
	output logic rs_full_o
);

	// station, cdb comes back for wakeup
	rs_core #(
		.RS_ENTRIES(RS_ENTRIES)
	) u_core (
		.clk(clk),
		.rst(rst),
		.dispatch_vld_i(dispatch_vld_i),
		.dispatch_i(dispatch_i),
		.cdb_i(cdb_o),
		.br_i(br_i),
		.ld_iss_en_i(ld_iss_en_i),
		.iss_hold_i(iss_hold_i),
		.iss_vld_o(iss_vld_o),
		.iss_o(iss_o),
		.rs_full_o(rs_full_o)
	);

	// stand-in for the functional units
	ex_latency_pipe u_ex (
		.clk(clk),
		.rst(rst),
		.iss_vld_i(iss_vld_o),
		.iss_i(iss_o),
		.cdb_o(cdb_o)
	);

endmodule

/* rtl/ex_latency_pipe.sv */
`timescale 1ns/1ps

module ex_latency_pipe (
	input  logic clk,
	input  logic rst,
	input  logic iss_vld_i,
	input  rs_types_pkg::rs_issue_t iss_i,
	output rs_types_pkg::cdb_t cdb_o
);

	import rs_cfg_pkg::*;
	import rs_types_pkg::*;

	// slot d reaches the cdb d cycles from now
	cdb_t [LAT_MAX-1:0] pipe_r;
	cdb_t [LAT_MAX-1:0] pipe_nxt;
	int unsigned iss_lat;

	assign iss_lat = fu_lat(iss_i.fu_sel);

	always_comb begin
		for (int d = 0; d < LAT_MAX - 1; d++) begin
			pipe_nxt[d] = pipe_r[d+1];
		end
		pipe_nxt[LAT_MAX-1] = '0;
		// slot is known free, the scheduler reserved it at select
		if (iss_vld_i && iss_lat != 0) begin
			pipe_nxt[iss_lat-1].vld = 1'b1;
			pipe_nxt[iss_lat-1].tag = iss_i.dest_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pipe_r <= '0;
		end else begin
			pipe_r <= pipe_nxt;
		end
	end

	assign cdb_o = pipe_r[0];

endmodule

/* rtl/rs_core.sv */
`timescale 1ns/1ps

module rs_core #(
	parameter int RS_ENTRIES = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic dispatch_vld_i,
	input  rs_types_pkg::rs_dispatch_t dispatch_i,
	input  rs_types_pkg::cdb_t cdb_i,
	input  rs_types_pkg::br_event_t br_i,
	input  logic ld_iss_en_i,
	input  logic iss_hold_i,
	output logic iss_vld_o,
	output rs_types_pkg::rs_issue_t iss_o,
	output logic rs_full_o
);

	import rs_cfg_pkg::*;
	import rs_types_pkg::*;

	localparam int IDX_W = $clog2(RS_ENTRIES);

	logic [RS_ENTRIES-1:0] busy_vec;
	logic [RS_ENTRIES-1:0] ready_vec;
	logic [RS_ENTRIES-1:0] load_vec;
	logic [RS_ENTRIES-1:0] issue_vec;
	logic [RS_ENTRIES-1:0] free_pick;
	rs_issue_t [RS_ENTRIES-1:0] op_vec;
	fu_sel_e [RS_ENTRIES-1:0] fu_vec;
	logic [RS_ENTRIES-1:0][ROB_IDX_W:0] age_vec;
	logic [RS_ENTRIES-1:0] is_ld_vec;
	logic [RS_ENTRIES-1:0] allow_vec;
	logic [RS_ENTRIES-1:0] req_ld;
	logic [RS_ENTRIES-1:0] req_oth;
	logic [RS_ENTRIES-1:0] gnt_ld;
	logic [RS_ENTRIES-1:0] gnt_oth;
	logic [IDX_W-1:0] idx_ld;
	logic [IDX_W-1:0] idx_oth;
	logic [IDX_W-1:0] sel_idx;
	logic vld_ld;
	logic vld_oth;
	logic use_ld;
	logic sel_vld;
	rs_issue_t sel_op;
	logic mispredict;
	logic sel_kill;
	logic iss_go;
	logic no_free;
	logic dp_en;
	logic wrap_flip_r;
	logic [BR_MASK_W-1:0] clr_mask;

	// ************************************************************************
	// station slots
	// ************************************************************************

	for (genvar i = 0; i < RS_ENTRIES; i++) begin : g_entry
		rs_entry u_entry (
			.clk(clk),
			.rst(rst),
			.load_i(load_vec[i]),
			.disp_i(dispatch_i),
			.issue_i(issue_vec[i]),
			.cdb_i(cdb_i),
			.br_i(br_i),
			.busy_o(busy_vec[i]),
			.ready_o(ready_vec[i]),
			.op_o(op_vec[i])
		);

		assign fu_vec[i] = op_vec[i].fu_sel;
		assign age_vec[i] = op_vec[i].rob_idx;
		assign is_ld_vec[i] = (op_vec[i].fu_sel == FU_LOAD);
	end

	// ************************************************************************
	// dispatch
	// ************************************************************************

	assign mispredict = br_i.resolve & br_i.mispredict;
	assign clr_mask = (br_i.resolve & ~br_i.mispredict) ? br_i.tag : '0;

	// lowest clear bit of busy_vec
	assign free_pick = ~busy_vec & (busy_vec + RS_ENTRIES'(1));
	assign no_free = &busy_vec;
	assign rs_full_o = no_free & ~iss_go;
	assign dp_en = dispatch_vld_i & ~mispredict & ~rs_full_o;

	// when full, the slot being issued this cycle takes the new op
	assign load_vec = !dp_en ? '0 : (no_free ? issue_vec : free_pick);

	// polarity of the youngest dispatch decides which lap is older
	always_ff @(posedge clk) begin
		if (rst) begin
			wrap_flip_r <= 1'b0;
		end else if (dp_en) begin
			wrap_flip_r <= ~dispatch_i.rob_idx[ROB_IDX_W];
		end
	end

	// ************************************************************************
	// issue select
	// ************************************************************************

	wb_slot_sched #(
		.RS_ENTRIES(RS_ENTRIES)
	) u_sched (
		.clk(clk),
		.rst(rst),
		.hold_i(iss_hold_i),
		.cand_fu_i(fu_vec),
		.take_i(sel_vld & ~sel_kill),
		.take_fu_i(sel_op.fu_sel),
		.allow_o(allow_vec)
	);

	assign req_ld = ready_vec & allow_vec & is_ld_vec;
	assign req_oth = ready_vec & allow_vec & ~is_ld_vec;

	age_select #(
		.RS_ENTRIES(RS_ENTRIES)
	) u_sel_ld (
		.req_i(req_ld),
		.age_i(age_vec),
		.wrap_flip_i(wrap_flip_r),
		.gnt_o(gnt_ld),
		.idx_o(idx_ld),
		.vld_o(vld_ld)
	);

	age_select #(
		.RS_ENTRIES(RS_ENTRIES)
	) u_sel_oth (
		.req_i(req_oth),
		.age_i(age_vec),
		.wrap_flip_i(wrap_flip_r),
		.gnt_o(gnt_oth),
		.idx_o(idx_oth),
		.vld_o(vld_oth)
	);

	// load lane has priority while the load queue allows it
	assign use_ld = vld_ld & ld_iss_en_i;
	assign sel_vld = use_ld | vld_oth;
	assign sel_idx = use_ld ? idx_ld : idx_oth;
	assign sel_op = op_vec[sel_idx];

	// wrong-path op picked in the mispredict cycle is dropped
	assign sel_kill = mispredict & (|(sel_op.br_mask & br_i.tag));
	assign iss_go = sel_vld & ~iss_hold_i & ~sel_kill;
	assign issue_vec = !iss_go ? '0 : (use_ld ? gnt_ld : gnt_oth);

	// issue register
	always_ff @(posedge clk) begin
		if (rst) begin
			iss_vld_o <= 1'b0;
		end else begin
			iss_vld_o <= iss_go;
		end
	end

	always_ff @(posedge clk) begin
		if (iss_go) begin
			iss_o <= sel_op;
			iss_o.br_mask <= sel_op.br_mask & ~clr_mask;
		end
	end

endmodule

/* rtl/wb_slot_sched.sv */
`timescale 1ns/1ps

module wb_slot_sched #(
	parameter int RS_ENTRIES = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic hold_i,
	input  rs_types_pkg::fu_sel_e [RS_ENTRIES-1:0] cand_fu_i,
	input  logic take_i,
	input  rs_types_pkg::fu_sel_e take_fu_i,
	output logic [RS_ENTRIES-1:0] allow_o
);

	import rs_cfg_pkg::*;
	import rs_types_pkg::*;

	// bit k set: cdb already taken k+1 cycles after the next edge
	logic [LAT_MAX-1:0] resv_r;
	logic [LAT_MAX-1:0] resv_nxt;
	logic [LAT_MAX:0] busy_ext;
	int unsigned take_lat;
	int unsigned cand_lat;

	assign take_lat = fu_lat(take_fu_i);

	// results already in flight keep draining during a hold,
	// only new reservations stop
	always_comb begin
		resv_nxt = resv_r >> 1;
		if (take_i && !hold_i && take_lat != 0) begin
			resv_nxt[take_lat-1] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			resv_r <= '0;
		end else begin
			resv_r <= resv_nxt;
		end
	end

	// a candidate picked now lands on the cdb lat cycles after the edge
	assign busy_ext = {1'b0, resv_r};

	always_comb begin
		cand_lat = 0;
		for (int i = 0; i < RS_ENTRIES; i++) begin
			cand_lat = fu_lat(cand_fu_i[i]);
			allow_o[i] = (cand_lat == 0) || !busy_ext[cand_lat];
		end
	end

endmodule

/* rtl/age_select.sv */
`timescale 1ns/1ps

module age_select #(
	parameter int RS_ENTRIES = 8
) (
	input  logic [RS_ENTRIES-1:0] req_i,
	input  logic [RS_ENTRIES-1:0][rs_cfg_pkg::ROB_IDX_W:0] age_i,
	input  logic wrap_flip_i,
	output logic [RS_ENTRIES-1:0] gnt_o,
	output logic [$clog2(RS_ENTRIES)-1:0] idx_o,
	output logic vld_o
);

	import rs_cfg_pkg::*;

	localparam int IDX_W = $clog2(RS_ENTRIES);
	localparam int NODES = 2 * RS_ENTRIES - 1;

	// heap layout, leaves at RS_ENTRIES-1 and up, root at 0
	logic [NODES-1:0] node_vld;
	logic [NODES-1:0][ROB_IDX_W:0] node_age;
	logic [NODES-1:0][IDX_W-1:0] node_idx;
	logic left_wins;

	always_comb begin
		left_wins = 1'b0;
		for (int i = 0; i < RS_ENTRIES; i++) begin
			node_vld[RS_ENTRIES-1+i] = req_i[i];
			// once the rob has wrapped the old lap must sort lower
			node_age[RS_ENTRIES-1+i] = {age_i[i][ROB_IDX_W] ^ wrap_flip_i,
				age_i[i][ROB_IDX_W-1:0]};
			node_idx[RS_ENTRIES-1+i] = IDX_W'(i);
		end
		for (int n = RS_ENTRIES - 2; n >= 0; n--) begin
			left_wins = node_vld[2*n+1] &
				(~node_vld[2*n+2] | (node_age[2*n+1] <= node_age[2*n+2]));
			node_vld[n] = node_vld[2*n+1] | node_vld[2*n+2];
			node_age[n] = left_wins ? node_age[2*n+1] : node_age[2*n+2];
			node_idx[n] = left_wins ? node_idx[2*n+1] : node_idx[2*n+2];
		end
	end

	always_comb begin
		gnt_o = '0;
		if (node_vld[0]) begin
			gnt_o[node_idx[0]] = 1'b1;
		end
	end

	assign idx_o = node_idx[0];
	assign vld_o = node_vld[0];

endmodule

/* rtl/rs_entry.sv */
`timescale 1ns/1ps

module rs_entry (
	input  logic clk,
	input  logic rst,
	input  logic load_i,
	input  rs_types_pkg::rs_dispatch_t disp_i,
	input  logic issue_i,
	input  rs_types_pkg::cdb_t cdb_i,
	input  rs_types_pkg::br_event_t br_i,
	output logic busy_o,
	output logic ready_o,
	output rs_types_pkg::rs_issue_t op_o
);

	import rs_cfg_pkg::*;
	import rs_types_pkg::*;

	logic busy_r;
	logic opa_rdy_r;
	logic opb_rdy_r;
	rs_issue_t op_r;
	logic squash;
	logic [BR_MASK_W-1:0] clr_mask;
	logic disp_opa_hit;
	logic disp_opb_hit;
	logic opa_hit;
	logic opb_hit;

	// branch upkeep
	assign squash = br_i.resolve & br_i.mispredict & (|(op_r.br_mask & br_i.tag));
	assign clr_mask = (br_i.resolve & ~br_i.mispredict) ? br_i.tag : '0;

	// wakeup, for the incoming op and the held one
	assign disp_opa_hit = cdb_i.vld & (cdb_i.tag == disp_i.opa_tag);
	assign disp_opb_hit = cdb_i.vld & (cdb_i.tag == disp_i.opb_tag);
	assign opa_hit = cdb_i.vld & (cdb_i.tag == op_r.opa_tag);
	assign opb_hit = cdb_i.vld & (cdb_i.tag == op_r.opb_tag);

	// a load in the issuing cycle refills the slot, so load wins
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_r <= 1'b0;
		end else if (load_i) begin
			busy_r <= 1'b1;
		end else if (issue_i | squash) begin
			busy_r <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load_i) begin
			op_r.dest_tag <= disp_i.dest_tag;
			op_r.opa_tag <= disp_i.opa_tag;
			op_r.opb_tag <= disp_i.opb_tag;
			op_r.fu_sel <= disp_i.fu_sel;
			op_r.rob_idx <= disp_i.rob_idx;
			op_r.br_mask <= disp_i.br_mask & ~clr_mask;
			opa_rdy_r <= disp_i.opa_rdy | disp_opa_hit;
			opb_rdy_r <= disp_i.opb_rdy | disp_opb_hit;
		end else begin
			op_r.br_mask <= op_r.br_mask & ~clr_mask;
			opa_rdy_r <= opa_rdy_r | opa_hit;
			opb_rdy_r <= opb_rdy_r | opb_hit;
		end
	end

	assign busy_o = busy_r;
	assign ready_o = busy_r & opa_rdy_r & opb_rdy_r;
	assign op_o = op_r;

endmodule

/* rtl/rs_types_pkg.sv */
package rs_types_pkg;

	import rs_cfg_pkg::*;

	typedef enum logic [2:0] {
		FU_NONE = 3'd0,
		FU_ALU = 3'd1,
		FU_BRANCH = 3'd2,
		FU_LOAD = 3'd3,
		FU_MULT = 3'd4
	} fu_sel_e;

	// op as it comes out of rename
	typedef struct packed {
		logic [PRF_TAG_W-1:0] dest_tag;
		logic [PRF_TAG_W-1:0] opa_tag;
		logic [PRF_TAG_W-1:0] opb_tag;
		logic opa_rdy;
		logic opb_rdy;
		fu_sel_e fu_sel;
		logic [ROB_IDX_W:0] rob_idx;
		logic [BR_MASK_W-1:0] br_mask;
	} rs_dispatch_t;

	// op as it leaves the station, ready flags no longer needed
	typedef struct packed {
		logic [PRF_TAG_W-1:0] dest_tag;
		logic [PRF_TAG_W-1:0] opa_tag;
		logic [PRF_TAG_W-1:0] opb_tag;
		fu_sel_e fu_sel;
		logic [ROB_IDX_W:0] rob_idx;
		logic [BR_MASK_W-1:0] br_mask;
	} rs_issue_t;

	typedef struct packed {
		logic vld;
		logic [PRF_TAG_W-1:0] tag;
	} cdb_t;

	// tag is one-hot, mispredict only meaningful with resolve
	typedef struct packed {
		logic resolve;
		logic mispredict;
		logic [BR_MASK_W-1:0] tag;
	} br_event_t;

	// 0 means no result on the cdb
	function automatic int unsigned fu_lat(fu_sel_e fu);
		case (fu)
			FU_ALU: return LAT_ALU;
			FU_BRANCH: return LAT_BRANCH;
			FU_LOAD: return LAT_LOAD;
			FU_MULT: return LAT_MULT;
			default: return 0;
		endcase
	endfunction

endpackage

/* rtl/rs_cfg_pkg.sv */
package rs_cfg_pkg;

	// ************************************************************************
	// widths
	// ************************************************************************

	// physical register tag
	localparam int PRF_TAG_W = 6;

	// rob index, wrap bit sits on top of this
	localparam int ROB_IDX_W = 4;

	// one bit per unresolved branch
	localparam int BR_MASK_W = 4;

	// ************************************************************************
	// execution latencies, in cycles from issue to cdb
	// ************************************************************************

	// also the depth of the slot scheduler and the ex pipe
	localparam int unsigned LAT_MAX = 4;

	localparam int unsigned LAT_ALU = 1;
	localparam int unsigned LAT_BRANCH = 1;
	localparam int unsigned LAT_LOAD = 3;
	localparam int unsigned LAT_MULT = 4;

endpackage
